/* hw/cpu_pkg.sv */
package cpu_pkg;

    // Widths
    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    // Class and function fields
    localparam int class_msb = 31;
    localparam int class_lsb = 29;
    localparam int func_msb  = 28;
    localparam int func_lsb  = 25;

    // Register fields shared by all classes
    localparam int dest_msb = 24;
    localparam int dest_lsb = 20;
    localparam int src1_msb = 19;
    localparam int src1_lsb = 15;
    localparam int src2_msb = 14;
    localparam int src2_lsb = 10;

    // Offsets, either one 15-bit field or split high and low parts
    localparam int offset_width = 15;
    localparam int off_hi_msb   = 24;
    localparam int off_hi_lsb   = 20;
    localparam int off_lo_msb   = 9;
    localparam int off_lo_lsb   = 0;

    // Instruction classes, anything else is a no-op
    localparam logic [2:0] class_r = 3'd0;
    localparam logic [2:0] class_m = 3'd1;
    localparam logic [2:0] class_b = 3'd2;

    // R class: low two bits pick the ALU op, MUL is not implemented
    localparam logic [3:0] op_mul = 4'd4;

    // M class
    localparam logic [3:0] op_ldw = 4'd1;
    localparam logic [3:0] op_stw = 4'd3;

    // B class
    localparam logic [3:0] op_beq = 4'd0;

    // ALU operations
    localparam logic [1:0] alu_add = 2'd0;
    localparam logic [1:0] alu_sub = 2'd1;
    localparam logic [1:0] alu_and = 2'd2;
    localparam logic [1:0] alu_or  = 2'd3;

endpackage

/* hw/cpu_fetch.sv */
module cpu_fetch
    import cpu_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  logic [data_width-1:0]         imem_wdata,
    input  logic                          branch_taken,
    input  logic [data_width-1:0]         branch_target,
    output logic                          if_valid,
    output logic [data_width-1:0]         if_instr,
    output logic [data_width-1:0]         if_next_pc
);

    logic [data_width-1:0] imem [IMEM_WORDS];
    logic [data_width-1:0] pc;

    // Load port, only used while run is low
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            // Drop the word being fetched and restart at the target
            pc       <= branch_target;
            if_valid <= 1'b0;
        end else begin
            if_valid <= run;
            if (run) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (run && !branch_taken) begin
            if_instr   <= imem[pc[$clog2(IMEM_WORDS)-1:0]];
            if_next_pc <= pc + 1'b1;
        end
    end

endmodule

/* hw/cpu_reg_bank.sv */
module cpu_reg_bank
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [reg_addr_width-1:0] rd_addr_a,
    input  logic [reg_addr_width-1:0] rd_addr_b,
    input  logic                      wr_en,
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [data_width-1:0]     wr_data,
    output logic [data_width-1:0]     rd_data_a,
    output logic [data_width-1:0]     rd_data_b
);

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero, a write in flight is seen by the reader
    always_comb begin
        if (rd_addr_a == '0)                     rd_data_a = '0;
        else if (wr_en && wr_addr == rd_addr_a)  rd_data_a = wr_data;
        else                                     rd_data_a = regs[rd_addr_a];

        if (rd_addr_b == '0)                     rd_data_b = '0;
        else if (wr_en && wr_addr == rd_addr_b)  rd_data_b = wr_data;
        else                                     rd_data_b = regs[rd_addr_b];
    end

endmodule

/* hw/cpu_decode.sv */
module cpu_decode
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      if_valid,
    input  logic [data_width-1:0]     if_instr,
    input  logic [data_width-1:0]     if_next_pc,
    input  logic [data_width-1:0]     rd_data_a,
    input  logic [data_width-1:0]     rd_data_b,
    output logic [reg_addr_width-1:0] rd_addr_a,
    output logic [reg_addr_width-1:0] rd_addr_b,
    output logic                      id_valid,
    output logic                      id_reg_write,
    output logic                      id_mem_to_reg,
    output logic                      id_mem_write,
    output logic                      id_branch,
    output logic                      id_use_reg_b,
    output logic [1:0]                id_alu_op,
    output logic [data_width-1:0]     id_ra_data,
    output logic [data_width-1:0]     id_rb_data,
    output logic [data_width-1:0]     id_offset,
    output logic [data_width-1:0]     id_next_pc,
    output logic [reg_addr_width-1:0] id_reg_dest
);

    logic [2:0]              cls;
    logic [3:0]              func;
    logic [offset_width-1:0] long_off;
    logic [offset_width-1:0] split_off;
    logic                    reg_write, mem_to_reg, mem_write, branch, use_reg_b;
    logic [1:0]              alu_op;
    logic [data_width-1:0]   offset;
    logic                    take;

    assign cls       = if_instr[class_msb:class_lsb];
    assign func      = if_instr[func_msb:func_lsb];
    assign long_off  = if_instr[offset_width-1:0];
    assign split_off = {if_instr[off_hi_msb:off_hi_lsb], if_instr[off_lo_msb:off_lo_lsb]};
    assign rd_addr_a = if_instr[src1_msb:src1_lsb];
    assign rd_addr_b = if_instr[src2_msb:src2_lsb];
    assign take      = if_valid && !flush;

    always_comb begin
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        use_reg_b  = 1'b0;
        alu_op     = alu_add;
        offset     = {{(data_width-offset_width){long_off[offset_width-1]}}, long_off};
        case (cls)
            class_r: begin
                if (func != op_mul) begin
                    reg_write = 1'b1;
                    use_reg_b = 1'b1;
                    alu_op    = func[1:0];
                end
            end
            class_m: begin
                if (func == op_ldw) begin
                    reg_write  = 1'b1;
                    mem_to_reg = 1'b1;
                end else if (func == op_stw) begin
                    mem_write = 1'b1;
                    offset    = {{(data_width-offset_width){split_off[offset_width-1]}}, split_off};
                end
            end
            class_b: begin
                // Compare by subtracting rb from ra
                if (func == op_beq) begin
                    branch    = 1'b1;
                    use_reg_b = 1'b1;
                    alu_op    = alu_sub;
                    offset    = {{(data_width-offset_width){split_off[offset_width-1]}}, split_off};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_valid      <= 1'b0;
            id_reg_write  <= 1'b0;
            id_mem_to_reg <= 1'b0;
            id_mem_write  <= 1'b0;
            id_branch     <= 1'b0;
            id_use_reg_b  <= 1'b0;
            id_alu_op     <= alu_add;
        end else begin
            id_valid      <= take;
            id_reg_write  <= take && reg_write;
            id_mem_to_reg <= mem_to_reg;
            id_mem_write  <= take && mem_write;
            id_branch     <= take && branch;
            id_use_reg_b  <= use_reg_b;
            id_alu_op     <= alu_op;
        end
    end

    always_ff @(posedge clock) begin
        id_ra_data  <= rd_data_a;
        id_rb_data  <= rd_data_b;
        id_offset   <= offset;
        id_next_pc  <= if_next_pc;
        id_reg_dest <= if_instr[dest_msb:dest_lsb];
    end

endmodule

/* hw/cpu_execute.sv */
module cpu_execute
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      id_valid,
    input  logic                      id_reg_write,
    input  logic                      id_mem_to_reg,
    input  logic                      id_mem_write,
    input  logic                      id_branch,
    input  logic                      id_use_reg_b,
    input  logic [1:0]                id_alu_op,
    input  logic [data_width-1:0]     id_ra_data,
    input  logic [data_width-1:0]     id_rb_data,
    input  logic [data_width-1:0]     id_offset,
    input  logic [data_width-1:0]     id_next_pc,
    input  logic [reg_addr_width-1:0] id_reg_dest,
    output logic                      branch_taken,
    output logic [data_width-1:0]     branch_target,
    output logic                      ex_valid,
    output logic                      ex_reg_write,
    output logic                      ex_mem_to_reg,
    output logic                      ex_mem_write,
    output logic [data_width-1:0]     ex_result,
    output logic [data_width-1:0]     ex_store_data,
    output logic [reg_addr_width-1:0] ex_reg_dest
);

    logic [data_width-1:0] alu_b;
    logic [data_width-1:0] alu_result;

    assign alu_b = id_use_reg_b ? id_rb_data : id_offset;

    always_comb begin
        case (id_alu_op)
            alu_add: alu_result = id_ra_data + alu_b;
            alu_sub: alu_result = id_ra_data - alu_b;
            alu_and: alu_result = id_ra_data & alu_b;
            default: alu_result = id_ra_data | alu_b;
        endcase
    end

    // Equal operands give a zero difference
    assign branch_taken  = id_valid && id_branch && (alu_result == '0);
    assign branch_target = id_next_pc + id_offset;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_write  <= 1'b0;
        end else begin
            ex_valid      <= id_valid;
            ex_reg_write  <= id_valid && id_reg_write;
            ex_mem_to_reg <= id_mem_to_reg;
            ex_mem_write  <= id_valid && id_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        ex_result     <= alu_result;
        ex_store_data <= id_rb_data;
        ex_reg_dest   <= id_reg_dest;
    end

endmodule

/* hw/cpu_mem_wb.sv */
module cpu_mem_wb
    import cpu_pkg::*;
#(
    parameter int DMEM_WORDS = 16
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          ex_valid,
    input  logic                          ex_reg_write,
    input  logic                          ex_mem_to_reg,
    input  logic                          ex_mem_write,
    input  logic [data_width-1:0]         ex_result,
    input  logic [data_width-1:0]         ex_store_data,
    input  logic [reg_addr_width-1:0]     ex_reg_dest,
    output logic                          wb_valid,
    output logic [reg_addr_width-1:0]     wb_reg,
    output logic [data_width-1:0]         wb_data,
    output logic                          st_valid,
    output logic [$clog2(DMEM_WORDS)-1:0] st_addr,
    output logic [data_width-1:0]         st_data
);

    logic [data_width-1:0]         dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] idx;
    logic                          do_store;

    // Low address bits wrap the word address into the memory
    assign idx      = ex_result[$clog2(DMEM_WORDS)-1:0];
    assign do_store = ex_valid && ex_mem_write;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
            wb_valid <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            if (do_store) begin
                dmem[idx] <= ex_store_data;
            end
            wb_valid <= ex_valid && ex_reg_write && (ex_reg_dest != '0);
            st_valid <= do_store;
        end
    end

    always_ff @(posedge clock) begin
        wb_reg  <= ex_reg_dest;
        wb_data <= ex_mem_to_reg ? dmem[idx] : ex_result;
        st_addr <= idx;
        st_data <= ex_store_data;
    end

endmodule

/* hw/cpu_core.sv */
module cpu_core
    import cpu_pkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 16
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  logic [data_width-1:0]         imem_wdata,
    output logic                          wb_valid,
    output logic [reg_addr_width-1:0]     wb_reg,
    output logic [data_width-1:0]         wb_data,
    output logic                          st_valid,
    output logic [$clog2(DMEM_WORDS)-1:0] st_addr,
    output logic [data_width-1:0]         st_data
);

    logic                      if_valid;
    logic [data_width-1:0]     if_instr, if_next_pc;
    logic [reg_addr_width-1:0] rd_addr_a, rd_addr_b;
    logic [data_width-1:0]     rd_data_a, rd_data_b;
    logic                      id_valid, id_reg_write, id_mem_to_reg, id_mem_write;
    logic                      id_branch, id_use_reg_b;
    logic [1:0]                id_alu_op;
    logic [data_width-1:0]     id_ra_data, id_rb_data, id_offset, id_next_pc;
    logic [reg_addr_width-1:0] id_reg_dest;
    logic                      branch_taken;
    logic [data_width-1:0]     branch_target;
    logic                      ex_valid, ex_reg_write, ex_mem_to_reg, ex_mem_write;
    logic [data_width-1:0]     ex_result, ex_store_data;
    logic [reg_addr_width-1:0] ex_reg_dest;

    cpu_fetch #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (.*);

    cpu_reg_bank reg_bank_i (
        .clock, .reset, .rd_addr_a, .rd_addr_b,
        .wr_en(wb_valid), .wr_addr(wb_reg), .wr_data(wb_data),
        .rd_data_a, .rd_data_b
    );

    cpu_decode decode_i (.*, .flush(branch_taken));

    cpu_execute execute_i (.*);

    cpu_mem_wb #(.DMEM_WORDS(DMEM_WORDS)) mem_wb_i (.*);

endmodule

/* sim/cpu_core_chk.sv */
module cpu_core_chk
    import cpu_pkg::*;
(
    input logic                      clock,
    input logic                      reset,
    input logic                      wb_valid,
    input logic [reg_addr_width-1:0] wb_reg,
    input logic                      st_valid,
    input logic                      branch_taken
);

    wb_not_r0: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> wb_reg != '0)
        else $error("writeback to r0");

    one_event: assert property (@(posedge clock) disable iff (reset)
        !(wb_valid && st_valid))
        else $error("writeback and store in the same cycle");

    // Flushed slots are bubbles in execute
    no_branch_in_flush: assert property (@(posedge clock) disable iff (reset)
        branch_taken |=> !branch_taken ##1 !branch_taken)
        else $error("branch taken from a flushed slot");

    // Flushed slots would reach writeback three and four cycles later
    no_event_from_flush: assert property (@(posedge clock) disable iff (reset)
        branch_taken |-> ##3 !(wb_valid || st_valid) ##1 !(wb_valid || st_valid))
        else $error("event from a flushed slot");

endmodule

bind cpu_core cpu_core_chk chk_i (.*);

/* sim/cpu_core_tb.sv */
module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int imem_words = 64;
    localparam int dmem_words = 16;
    localparam int wait_limit = 2000;
    localparam logic [31:0] nop_word = {3'd7, 29'd0};

    logic                          clock;
    logic                          reset;
    logic                          run;
    logic                          imem_we;
    logic [$clog2(imem_words)-1:0] imem_addr;
    logic [data_width-1:0]         imem_wdata;
    logic                          wb_valid;
    logic [reg_addr_width-1:0]     wb_reg;
    logic [data_width-1:0]         wb_data;
    logic                          st_valid;
    logic [$clog2(dmem_words)-1:0] st_addr;
    logic [data_width-1:0]         st_data;

    logic [31:0] prog [imem_words];
    int          prog_len;
    logic [15:0] lfsr_state;
    // Expected events hold a store flag, a register or address and the data
    logic [37:0] exp_q [$];
    int          errors;
    int          tests_done;
    int          tests_bad;

    cpu_core #(
        .IMEM_WORDS(imem_words),
        .DMEM_WORDS(dmem_words)
    ) cpu_core_i (.*);

    always #50 clock = ~clock;

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            bits       = {bits[30:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] alu_word(input logic [3:0] fn, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {class_r, fn, rd, rs1, rs2, 10'd0};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] base,
                                              input logic [14:0] off);
        return {class_m, op_ldw, rd, base, off};
    endfunction

    // STW and BEQ carry the offset around the source fields
    function automatic logic [31:0] split_word(input logic [2:0] cls, input logic [3:0] fn,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [14:0] off);
        return {cls, fn, off[14:10], rs1, rs2, off[9:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Two empty slots keep any consumer three slots behind
    task automatic place_spaced(input logic [31:0] word);
        emit(word);
        emit(nop_word);
        emit(nop_word);
    endtask

    task automatic build_program(input int kind);
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [14:0] off;
        logic [2:0]  cls;
        logic [3:0]  fn;
        int          k;
        prog_len = 0;
        while (prog_len < imem_words - 10) begin
            rd  = 5'(take_bits(5));
            ra  = 5'(take_bits(5));
            rb  = 5'(take_bits(5));
            off = 15'(take_bits(15));
            fn  = {2'b00, 2'(take_bits(2))};
            case (kind)
                2: place_spaced(alu_word(fn, rd, ra, rb));
                3: begin
                    if (take_bits(1) == 1) begin
                        place_spaced(split_word(class_m, op_stw, ra, rb, off));
                    end else begin
                        place_spaced(load_word(rd, ra, off));
                    end
                end
                4: begin
                    if (take_bits(1) == 1) begin
                        place_spaced(alu_word(fn, rd, ra, rb));
                    end else begin
                        k = 2 + int'(take_bits(1));
                        if (take_bits(1) == 1) begin
                            rb = ra;
                        end
                        emit(split_word(class_b, op_beq, ra, rb, 15'(k)));
                        // Skipped slots read r0..r15 and write r16..r31
                        for (int i = 0; i < k; i++) begin
                            emit(alu_word({2'b00, 2'(take_bits(2))}, {1'b1, 4'(take_bits(4))},
                                          {1'b0, 4'(take_bits(4))}, {1'b0, 4'(take_bits(4))}));
                        end
                        emit(nop_word);
                        emit(nop_word);
                    end
                end
                default: begin
                    cls = 3'(take_bits(3));
                    if (cls < 3'd3) begin
                        cls = cls + 3'd3;
                    end
                    case (take_bits(3))
                        0: place_spaced(alu_word(fn, 5'd0, ra, rb));
                        1: place_spaced(alu_word(op_mul, rd, ra, rb));
                        2: place_spaced({cls, 29'(take_bits(29))});
                        3: place_spaced({class_m, 1'b1, 3'(take_bits(3)), 25'(take_bits(25))});
                        4: place_spaced({class_b, 1'b1, 3'(take_bits(3)), 25'(take_bits(25))});
                        5: place_spaced(alu_word(alu_add, rd, 5'd0, 5'd0));
                        6: place_spaced(split_word(class_m, op_stw, 5'd0, 5'd0, off));
                        default: place_spaced(load_word(rd, 5'd0, off));
                    endcase
                end
            endcase
        end
        emit(split_word(class_b, op_beq, 5'd0, 5'd0, 15'h7fff));
    endtask

    // Instruction-set model returning the event count or -1 if the end loop is never hit
    function automatic int cpu_ref();
        logic [31:0] regs [32];
        logic [31:0] dmem [dmem_words];
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] off_long;
        logic [31:0] off_split;
        logic [31:0] res;
        logic [3:0]  fn;
        logic [4:0]  dest;
        int          idx;
        int          pc;
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = '0;
        end
        pc = 0;
        for (int step = 0; step < 400; step++) begin
            instr     = prog[pc % imem_words];
            fn        = instr[func_msb:func_lsb];
            dest      = instr[dest_msb:dest_lsb];
            a         = regs[instr[src1_msb:src1_lsb]];
            b         = regs[instr[src2_msb:src2_lsb]];
            off_long  = {{17{instr[14]}}, instr[14:0]};
            off_split = {{17{instr[24]}}, instr[24:20], instr[9:0]};
            pc++;
            case (instr[class_msb:class_lsb])
                class_r: begin
                    if (fn != op_mul) begin
                        case (fn[1:0])
                            alu_add: res = a + b;
                            alu_sub: res = a - b;
                            alu_and: res = a & b;
                            default: res = a | b;
                        endcase
                        if (dest != 0) begin
                            regs[dest] = res;
                            exp_q.push_back({1'b0, dest, res});
                        end
                    end
                end
                class_m: begin
                    if (fn == op_ldw) begin
                        idx = (a + off_long) % dmem_words;
                        if (dest != 0) begin
                            regs[dest] = dmem[idx];
                            exp_q.push_back({1'b0, dest, dmem[idx]});
                        end
                    end else if (fn == op_stw) begin
                        idx       = (a + off_split) % dmem_words;
                        dmem[idx] = b;
                        exp_q.push_back({1'b1, 5'(idx), b});
                    end
                end
                class_b: begin
                    if (fn == op_beq && a == b) begin
                        if (off_split == 32'hffff_ffff) begin
                            return exp_q.size();
                        end
                        pc = pc + int'(off_split);
                    end
                end
                default: ;
            endcase
        end
        return -1;
    endfunction

    task automatic check_event(input logic is_store, input logic [4:0] where,
                               input logic [31:0] value);
        logic [37:0] expected;
        if (exp_q.size() == 0) begin
            $display("Extra %s event with nothing left to expect",
                     is_store ? "store" : "writeback");
            errors++;
        end else begin
            expected = exp_q.pop_front();
            if (expected[37] != is_store) begin
                $display("Event out of order: got a %s where the other kind was expected",
                         is_store ? "store" : "writeback");
                errors++;
            end else if (is_store) begin
                if (expected[35:32] != where[3:0]) begin
                    $display("MISMATCH st_addr: expected %h, got %h", expected[35:32], where[3:0]);
                    errors++;
                end
                if (expected[31:0] != value) begin
                    $display("MISMATCH st_data: expected %h, got %h", expected[31:0], value);
                    errors++;
                end
            end else begin
                if (expected[36:32] != where) begin
                    $display("MISMATCH wb_reg: expected %h, got %h", expected[36:32], where);
                    errors++;
                end
                if (expected[31:0] != value) begin
                    $display("MISMATCH wb_data: expected %h, got %h", expected[31:0], value);
                    errors++;
                end
            end
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            if (wb_valid) begin
                check_event(1'b0, wb_reg, wb_data);
            end
            if (st_valid) begin
                check_event(1'b1, {1'b0, st_addr}, st_data);
            end
        end
    end

    task automatic apply_reset();
        @(posedge clock);
        #10;
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #10;
        reset = 1'b0;
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_done++;
        if (errors != start_err) begin
            tests_bad++;
        end
        $display("test %0d %s: %0d errors", tests_done, name, errors - start_err);
    endtask

    // Builds a program, predicts its events and writes it through the load port
    task automatic load_program(input int kind);
        build_program(kind);
        if (cpu_ref() < 0) begin
            $display("Reference model never reached the end loop");
            errors++;
        end
        for (int i = 0; i < imem_words; i++) begin
            @(posedge clock);
            #10;
            imem_we    = 1'b1;
            imem_addr  = 6'(i);
            imem_wdata = (i < prog_len) ? prog[i] : {3'd7, 23'd0, 6'(i)};
        end
        @(posedge clock);
        #10;
        imem_we = 1'b0;
    endtask

    task automatic run_program(input int kind);
        int    start_err;
        int    cycles;
        string name;
        start_err = errors;
        case (kind)
            2: name = "alu";
            3: name = "store and load";
            4: name = "branch";
            default: name = "no-op and r0";
        endcase
        apply_reset();
        load_program(kind);
        run    = 1'b1;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d expected events never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        // Core spins in its end loop so any event now is extra
        repeat (30) @(posedge clock);
        #10;
        run = 1'b0;
        report_test(name, start_err);
    endtask

    initial begin
        int start_err;
        clock      = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        lfsr_state = 16'd26167;
        errors     = 0;
        tests_done = 0;
        tests_bad  = 0;
        apply_reset();
        start_err = errors;
        // A loaded program must stay parked while run is low
        load_program(2);
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            if (wb_valid !== 1'b0 || st_valid !== 1'b0) begin
                $display("Event seen while run was low");
                errors++;
            end
        end
        report_test("idle", start_err);
        for (int kind = 2; kind <= 5; kind++) begin
            for (int rep = 0; rep < 3; rep++) begin
                run_program(kind);
            end
        end
        $display("%0d tests, %0d failing, %0d errors", tests_done, tests_bad, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_reg_bank.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_mem_wb.sv
hw/cpu_core.sv
sim/cpu_core_chk.sv
sim/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/cpu_fetch.sv
      - hw/cpu_reg_bank.sv
      - hw/cpu_decode.sv
      - hw/cpu_execute.sv
      - hw/cpu_mem_wb.sv
      - hw/cpu_core.sv
  - target: simulation
    files:
      - sim/cpu_core_chk.sv
      - sim/cpu_core_tb.sv
